//--- verilog/sdmac_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDMAC FIFO sizing macros
// Depth, pointer and counter widths, lanes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SDMAC_CONFIG_SVH
`define SDMAC_CONFIG_SVH

`define SDMAC_FIFO_DEPTH  8     // Longword entries
`define SDMAC_PTR_W       3     // Next-in / next-out pointer width
`define SDMAC_CNT_W       4     // Fill counter, 0 to 8

`define SDMAC_LANES       4     // Byte lanes per longword
`define SDMAC_LANE_W      2     // Lane index width

`define SDMAC_LONG_W      32    // Memory side data
`define SDMAC_BYTE_W      8     // SCSI side data

`endif

//--- verilog/sdmacPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared data types and FSM state enums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "sdmac_config.svh"

package sdmacPkg;

    typedef logic [`SDMAC_LONG_W-1:0] longWord_t;   // Memory bus longword
    typedef logic [`SDMAC_BYTE_W-1:0] byte_t;       // SCSI data byte
    typedef logic [`SDMAC_LANE_W-1:0] lanePtr_t;    // Byte lane index, lane 0 = MSB

    // ACR direction field
    typedef enum logic {
        dirScsiToMem = 1'b0,
        dirMemToScsi = 1'b1
    } dmaDir_t;

    typedef enum logic [1:0] {cpuIdle, cpuLoad, cpuUnload} cpuState_t;

    typedef enum logic [1:0] {scsiIdle, scsiPack, scsiUnpack} scsiState_t;

endpackage

`default_nettype wire

//--- verilog/fifoBuffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Eight longword FIFO store
// Lane write enables, next-in/next-out
// Fill counter with full and empty flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "sdmac_config.svh"

module fifoBuffer import sdmacPkg::*; (
    input  logic                    ACR_WR,
    input  logic                    RST_FIFO_,
    input  logic [`SDMAC_LANES-1:0] laneWrite,  // Per-lane write enable at next-in
    input  longWord_t               dataIn,
    input  logic                    incNi,      // Step next-in pointer
    input  logic                    incNo,      // Step next-out pointer
    input  logic                    incFifo,    // Count up
    input  logic                    decFifo,    // Count down
    output longWord_t               headData,   // Entry at next-out
    output logic                    fifoFull,
    output logic                    fifoEmpty
);

    longWord_t                fifoMem [`SDMAC_FIFO_DEPTH];
    logic [`SDMAC_PTR_W-1:0]  nextIn;     // Entry being filled
    logic [`SDMAC_PTR_W-1:0]  nextOut;    // Head entry
    logic [`SDMAC_CNT_W-1:0]  fillCount;  // Completed entries held

    // Storage, one enable per byte lane
    always_ff @(posedge ACR_WR) begin
        for (int l = 0; l < `SDMAC_LANES; l++) begin
            if (laneWrite[l]) begin
                // Lane 0 sits in the top byte
                fifoMem[nextIn][(`SDMAC_LANES-1-l)*`SDMAC_BYTE_W +: `SDMAC_BYTE_W] <=
                    dataIn[(`SDMAC_LANES-1-l)*`SDMAC_BYTE_W +: `SDMAC_BYTE_W];
            end
        end
    end

    // Pointers wrap naturally at depth 8
    always_ff @(posedge ACR_WR or negedge RST_FIFO_) begin
        if (!RST_FIFO_) begin
            nextIn  <= '0;
            nextOut <= '0;
        end else begin
            if (incNi) nextIn <= nextIn + 1'b1;
            if (incNo) nextOut <= nextOut + 1'b1;
        end
    end

    // Up/down counter, push and pop together cancel
    always_ff @(posedge ACR_WR or negedge RST_FIFO_) begin
        if (!RST_FIFO_) begin
            fillCount <= '0;
        end else begin
            fillCount <= fillCount + `SDMAC_CNT_W'(incFifo) - `SDMAC_CNT_W'(decFifo);
        end
    end

    assign headData  = fifoMem[nextOut];                               // Async read of head
    assign fifoEmpty = (fillCount == '0);
    assign fifoFull  = (fillCount == `SDMAC_CNT_W'(`SDMAC_FIFO_DEPTH));

endmodule

`default_nettype wire

//--- verilog/bytePointer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte lane pointer and lane write decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "sdmac_config.svh"

module bytePointer import sdmacPkg::*; (
    input  logic                    ACR_WR,
    input  logic                    RST_FIFO_,
    input  logic                    acrLoad,    // ACR write strobe
    input  logic                    acrMid25,   // Width bit being written
    input  logic                    mid25,      // Width bit held in the ACR
    input  logic                    incBo,      // Step to next lane
    input  logic                    lByte,      // Byte load from SCSI side
    input  logic                    llWord,     // Lower half load from CPU side
    input  logic                    lhWord,     // Upper half load from CPU side
    output lanePtr_t                lanePtr,
    output logic                    boEq0,
    output logic                    boEq3,
    output logic [`SDMAC_LANES-1:0] laneWrite
);

    always_ff @(posedge ACR_WR or negedge RST_FIFO_) begin
        if (!RST_FIFO_) begin
            lanePtr <= '0;
        end else if (acrLoad) begin
            lanePtr <= acrMid25 ? 2'd2 : 2'd0;   // 16-bit mode starts on lane 2
        end else if (incBo) begin
            if (lanePtr == 2'd3) begin
                lanePtr <= mid25 ? 2'd2 : 2'd0;  // 16-bit mode only uses lanes 2 and 3
            end else begin
                lanePtr <= lanePtr + 2'd1;
            end
        end
    end

    assign boEq0 = (lanePtr == 2'd0);
    assign boEq3 = (lanePtr == 2'd3);

    // Byte loads hit one lane, word loads hit a half
    always_comb begin
        for (int l = 0; l < `SDMAC_LANES; l++) begin
            laneWrite[l] = (lByte && (lanePtr == lanePtr_t'(l)))
                        || (lhWord && (l < `SDMAC_LANES/2))     // Lanes 0, 1
                        || (llWord && (l >= `SDMAC_LANES/2));   // Lanes 2, 3
        end
    end

endmodule

`default_nettype wire

//--- verilog/cpuTransferFsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory side transfer FSM
// Word load strobes, push and pop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module cpuTransferFsm import sdmacPkg::*; (
    input  logic    ACR_WR,
    input  logic    RST_FIFO_,
    input  dmaDir_t dir,
    input  logic    mid25,      // 16-bit memory mode
    input  logic    memWrite,
    input  logic    memRead,
    input  logic    fifoFull,
    input  logic    fifoEmpty,
    output logic    llWord,
    output logic    lhWord,
    output logic    push,
    output logic    pop
);

    cpuState_t state;
    cpuState_t nextState;
    logic      memWriteQ;   // Sampled request pulses
    logic      memReadQ;
    logic      halfSel;     // Set once the upper half of a pair is stored

    always_ff @(posedge ACR_WR or negedge RST_FIFO_) begin
        if (!RST_FIFO_) begin
            memWriteQ <= 1'b0;
            memReadQ  <= 1'b0;
        end else begin
            memWriteQ <= memWrite;
            memReadQ  <= memRead;
        end
    end

    // Legality is decided here and nowhere else
    always_comb begin
        nextState = cpuIdle;
        case (state)
            cpuIdle: begin
                if (memWriteQ && (dir == dirMemToScsi) && !fifoFull) begin
                    nextState = cpuLoad;
                end else if (memReadQ && (dir == dirScsiToMem) && !fifoEmpty) begin
                    nextState = cpuUnload;
                end
            end
            cpuLoad:   nextState = cpuIdle;   // One cycle of strobes
            cpuUnload: nextState = cpuIdle;
            default:   nextState = cpuIdle;
        endcase
    end

    always_ff @(posedge ACR_WR or negedge RST_FIFO_) begin
        if (!RST_FIFO_) begin
            state <= cpuIdle;
        end else begin
            state <= nextState;
        end
    end

    // Alternates upper then lower in 16-bit mode
    always_ff @(posedge ACR_WR or negedge RST_FIFO_) begin
        if (!RST_FIFO_) begin
            halfSel <= 1'b0;
        end else if (!mid25) begin
            halfSel <= 1'b0;
        end else if (state == cpuLoad) begin
            halfSel <= ~halfSel;
        end
    end

    assign lhWord = (state == cpuLoad) && (!mid25 || !halfSel);
    assign llWord = (state == cpuLoad) && (!mid25 || halfSel);
    assign push   = llWord;                 // Longword complete once its lower half lands
    assign pop    = (state == cpuUnload);

endmodule

`default_nettype wire

//--- verilog/scsiTransferFsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SCSI side transfer FSM
// Byte pack/unpack, pointer stepping
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module scsiTransferFsm import sdmacPkg::*; (
    input  logic    ACR_WR,
    input  logic    RST_FIFO_,
    input  dmaDir_t dir,
    input  logic    scsiByteValid,  // Byte arriving from SCSI
    input  logic    scsiByteReq,    // SCSI wants the next byte
    input  logic    boEq3,          // Last lane of the longword
    input  logic    fifoFull,
    input  logic    fifoEmpty,
    output logic    lByte,
    output logic    incBo,
    output logic    push,
    output logic    pop
);

    scsiState_t state;
    scsiState_t nextState;
    logic       byteValidQ;
    logic       byteReqQ;

    always_ff @(posedge ACR_WR or negedge RST_FIFO_) begin
        if (!RST_FIFO_) begin
            byteValidQ <= 1'b0;
            byteReqQ   <= 1'b0;
        end else begin
            byteValidQ <= scsiByteValid;
            byteReqQ   <= scsiByteReq;
        end
    end

    always_comb begin
        nextState = scsiIdle;
        case (state)
            scsiIdle: begin
                // Pack only into a free entry
                if (byteValidQ && (dir == dirScsiToMem) && !fifoFull) begin
                    nextState = scsiPack;
                // Unpack only a present entry
                end else if (byteReqQ && (dir == dirMemToScsi) && !fifoEmpty) begin
                    nextState = scsiUnpack;
                end
            end
            scsiPack:   nextState = scsiIdle;
            scsiUnpack: nextState = scsiIdle;
            default:    nextState = scsiIdle;
        endcase
    end

    always_ff @(posedge ACR_WR or negedge RST_FIFO_) begin
        if (!RST_FIFO_) begin
            state <= scsiIdle;
        end else begin
            state <= nextState;
        end
    end

    // Strobes for the single step
    assign lByte = (state == scsiPack);
    assign incBo = (state == scsiPack) || (state == scsiUnpack);
    assign push  = (state == scsiPack) && boEq3;     // Last lane filled
    assign pop   = (state == scsiUnpack) && boEq3;   // Last lane sent

endmodule

`default_nettype wire

//--- verilog/sdmacFifoTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDMAC FIFO top with ACR register
// Strobe steering and data routing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "sdmac_config.svh"

module sdmacFifoTop import sdmacPkg::*; (
    input  logic      ACR_WR,
    input  logic      RST_FIFO_,
    input  logic      acrLoad,
    input  dmaDir_t   acrDir,
    input  logic      acrMid25,
    input  logic      memWrite,
    input  logic      memRead,
    input  longWord_t memLongIn,
    input  logic      scsiByteValid,
    input  byte_t     scsiByteIn,
    input  logic      scsiByteReq,
    output longWord_t memLongOut,
    output byte_t     scsiByteOut,
    output logic      fifoFull,
    output logic      fifoEmpty,
    output logic      boEq0,
    output logic      boEq3
);

    dmaDir_t                 dir;        // ACR direction field
    logic                    mid25;      // ACR width bit
    logic                    scsiToMem;
    longWord_t               memLongQ;   // Held until the load strobes
    byte_t                   scsiByteQ;
    longWord_t               dataIn;
    longWord_t               headData;
    lanePtr_t                lanePtr;
    logic [`SDMAC_LANES-1:0] laneWrite;
    logic                    llWord, lhWord, lByte, incBo;
    logic                    cpuPush, cpuPop, scsiPush, scsiPop;
    logic                    incNi, incNo, incFifo, decFifo;

    always_ff @(posedge ACR_WR or negedge RST_FIFO_) begin
        if (!RST_FIFO_) begin
            dir   <= dirScsiToMem;
            mid25 <= 1'b0;
        end else if (acrLoad) begin
            dir   <= acrDir;
            mid25 <= acrMid25;
        end
    end

    // Data is written two edges after its pulse
    always_ff @(posedge ACR_WR) begin
        if (memWrite) memLongQ <= memLongIn;
        if (scsiByteValid) scsiByteQ <= scsiByteIn;
    end

    assign scsiToMem = (dir == dirScsiToMem);

    // Push side and pop side swap with direction
    assign incNi   = (scsiToMem && scsiPush) || (!scsiToMem && cpuPush);
    assign incNo   = (scsiToMem && cpuPop) || (!scsiToMem && scsiPop);
    assign incFifo = incNi;
    assign decFifo = incNo;

    always_comb begin
        if (scsiToMem) begin
            dataIn = {`SDMAC_LANES{scsiByteQ}};              // Byte on every lane
        end else if (mid25) begin
            dataIn = {2{memLongQ[`SDMAC_LONG_W/2-1:0]}};     // Low half feeds either half
        end else begin
            dataIn = memLongQ;
        end
    end

    assign memLongOut  = headData;
    assign scsiByteOut = headData[(`SDMAC_LANES-1-int'(lanePtr))*`SDMAC_BYTE_W +: `SDMAC_BYTE_W];

    fifoBuffer buffer0 (
        .ACR_WR, .RST_FIFO_, .laneWrite, .dataIn,
        .incNi, .incNo, .incFifo, .decFifo,
        .headData, .fifoFull, .fifoEmpty
    );

    bytePointer bytePtr0 (
        .ACR_WR, .RST_FIFO_, .acrLoad, .acrMid25, .mid25,
        .incBo, .lByte, .llWord, .lhWord,
        .lanePtr, .boEq0, .boEq3, .laneWrite
    );

    cpuTransferFsm cpuFsm0 (
        .ACR_WR, .RST_FIFO_, .dir, .mid25, .memWrite, .memRead,
        .fifoFull, .fifoEmpty, .llWord, .lhWord,
        .push(cpuPush), .pop(cpuPop)
    );

    scsiTransferFsm scsiFsm0 (
        .ACR_WR, .RST_FIFO_, .dir, .scsiByteValid, .scsiByteReq,
        .boEq3, .fifoFull, .fifoEmpty, .lByte, .incBo,
        .push(scsiPush), .pop(scsiPop)
    );

endmodule

`default_nettype wire

//--- test/tbSdmacFifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// File driven SDMAC FIFO testbench
// Queue reference model and compare tasks
// Random interleaved stress burst
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "sdmac_config.svh"

module tbSdmacFifo import sdmacPkg::*; ();

    typedef enum {opAcr, opMemWrite, opMemRead, opByteIn, opByteOut, opFlags} op_t;

    logic      ACR_WR;
    logic      RST_FIFO_;
    logic      acrLoad;
    logic      acrMid25;
    dmaDir_t   acrDir;
    logic      memWrite;
    logic      memRead;
    longWord_t memLongIn;
    logic      scsiByteValid;
    byte_t     scsiByteIn;
    logic      scsiByteReq;
    longWord_t memLongOut;
    byte_t     scsiByteOut;
    logic      fifoFull;
    logic      fifoEmpty;
    logic      boEq0;
    logic      boEq3;

    longWord_t modelQ[$];   // Completed entries, head first
    longWord_t partial;     // Entry being filled
    lanePtr_t  modelPtr;
    dmaDir_t   modelDir;
    logic      modelMid;
    logic      modelHalf;   // Upper half already stored
    int        seed;
    int        opCount;

    sdmacFifoTop dut0 (.*);

    initial begin
        ACR_WR = 1'b0;
        forever #4 ACR_WR = ~ACR_WR;   // 8 ns period
    end

    task automatic failRun(string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkLong(string name, longWord_t exp, longWord_t act);
        if (act !== exp) begin
            failRun($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic checkByte(string name, byte_t exp, byte_t act);
        if (act !== exp) begin
            failRun($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic checkFlag(string name, bit exp, bit act);
        if (act !== exp) begin
            failRun($sformatf("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act));
        end
    endtask

    // Predicted empty, full, boEq0 and boEq3
    function automatic logic [3:0] modelFlags();
        return {modelQ.size() == 0, modelQ.size() == `SDMAC_FIFO_DEPTH,
                modelPtr == 2'd0, modelPtr == 2'd3};
    endfunction

    task automatic tick();
        @(posedge ACR_WR);
        #1;                        // Drive just after the edge
    endtask

    task automatic settleFlags(string after);
        int waitCount;
        waitCount = 0;
        repeat (2) @(posedge ACR_WR);   // Lanes and pointers update two edges after the pulse
        @(negedge ACR_WR);
        while ({fifoEmpty, fifoFull, boEq0, boEq3} !== modelFlags()) begin
            waitCount++;
            if (waitCount > 20) begin
                failRun($sformatf("Timeout: flags never settled after %s", after));
            end
            @(negedge ACR_WR);
        end
    endtask

    task automatic stepPtr();
        if (modelPtr == 2'd3) modelPtr = modelMid ? 2'd2 : 2'd0;   // 16-bit wraps to lane 2
        else modelPtr = modelPtr + 2'd1;
    endtask

    task automatic writeAcr(dmaDir_t d, logic mid);
        tick();
        acrLoad  = 1'b1;
        acrDir   = d;
        acrMid25 = mid;
        tick();
        acrLoad  = 1'b0;
        modelDir = d;
        modelMid = mid;
        modelPtr = mid ? 2'd2 : 2'd0;
        if (!mid) modelHalf = 1'b0;
        settleFlags("ACR write");
    endtask

    // Model follows the legality rules for each pulse
    task automatic transfer(logic mw, logic mr, logic bv, logic br,
                            longWord_t d, byte_t b, string what);
        logic cpuWr, cpuRd, byteIn, byteOut;
        cpuWr   = mw && (modelDir == dirMemToScsi) && (modelQ.size() < `SDMAC_FIFO_DEPTH);
        cpuRd   = mr && (modelDir == dirScsiToMem) && (modelQ.size() > 0);
        byteIn  = bv && (modelDir == dirScsiToMem) && (modelQ.size() < `SDMAC_FIFO_DEPTH);
        byteOut = br && (modelDir == dirMemToScsi) && (modelQ.size() > 0);
        tick();
        memWrite      = mw;
        memRead       = mr;
        scsiByteValid = bv;
        scsiByteReq   = br;
        memLongIn     = d;
        scsiByteIn    = b;
        tick();
        memWrite      = 1'b0;
        memRead       = 1'b0;
        scsiByteValid = 1'b0;
        scsiByteReq   = 1'b0;
        if (cpuRd) void'(modelQ.pop_front());
        if (byteOut) begin
            if (modelPtr == 2'd3) void'(modelQ.pop_front());   // Last lane sent
            stepPtr();
        end
        if (cpuWr && !modelMid) modelQ.push_back(d);
        else if (cpuWr && !modelHalf) begin
            partial[31:16] = d[15:0];                            // Upper half first
            modelHalf      = 1'b1;
        end else if (cpuWr) begin
            partial[15:0] = d[15:0];
            modelQ.push_back(partial);
            modelHalf     = 1'b0;
        end
        if (byteIn) begin
            partial[(3 - modelPtr) * 8 +: 8] = b;                // Lane 0 is the top byte
            if (modelPtr == 2'd3) modelQ.push_back(partial);
            stepPtr();
        end
        settleFlags(what);
    endtask

    task automatic runOp(op_t op, longWord_t a0, longWord_t a1, longWord_t a2, longWord_t a3);
        case (op)
            opAcr:      writeAcr(dmaDir_t'(a0[0]), a1[0]);
            opMemWrite: transfer(1'b1, 1'b0, 1'b0, 1'b0, a0, '0, "memWrite");
            opByteIn:   transfer(1'b0, 1'b0, 1'b1, 1'b0, '0, a0[7:0], "scsiByteValid");
            opMemRead: begin
                if ((modelDir == dirScsiToMem) && (modelQ.size() > 0)) begin
                    if (modelQ[0] !== a0) failRun("Input file longword differs from the model");
                    checkLong("memLongOut", a0, memLongOut);
                end
                transfer(1'b0, 1'b1, 1'b0, 1'b0, '0, '0, "memRead");
            end
            opByteOut: begin
                if ((modelDir == dirMemToScsi) && (modelQ.size() > 0)) begin
                    if (modelQ[0][(3 - modelPtr) * 8 +: 8] !== a0[7:0]) begin
                        failRun("Input file byte differs from the model");
                    end
                    checkByte("scsiByteOut", a0[7:0], scsiByteOut);
                end
                transfer(1'b0, 1'b0, 1'b0, 1'b1, '0, '0, "scsiByteReq");
            end
            opFlags: begin
                checkFlag("fifoEmpty", a0[0], fifoEmpty);
                checkFlag("fifoFull", a1[0], fifoFull);
                checkFlag("boEq0", a2[0], boEq0);
                checkFlag("boEq3", a3[0], boEq3);
            end
        endcase
    endtask

    // Concurrent packing and popping with the order checked at every pop
    task automatic stressBurst();
        logic [31:0] rnd;
        writeAcr(dirScsiToMem, 1'b0);
        for (int i = 0; i < 64; i++) begin
            rnd = $random(seed);
            if (rnd[1] && (modelQ.size() > 0)) checkLong("memLongOut", modelQ[0], memLongOut);
            transfer(1'b0, rnd[1], rnd[0], 1'b0, '0, rnd[15:8], "stress transfer");
        end
        while (modelQ.size() > 0) begin   // Drain what is left
            checkLong("memLongOut", modelQ[0], memLongOut);
            transfer(1'b0, 1'b1, 1'b0, 1'b0, '0, '0, "stress drain");
        end
    endtask

    initial begin
        int        fd;
        int        nArgs;
        int        c;
        string     opName;
        op_t       op;
        longWord_t arg [4];
        RST_FIFO_     = 1'b0;
        acrLoad       = 1'b0;
        acrDir        = dirScsiToMem;
        acrMid25      = 1'b0;
        memWrite      = 1'b0;
        memRead       = 1'b0;
        memLongIn     = '0;
        scsiByteValid = 1'b0;
        scsiByteIn    = '0;
        scsiByteReq   = 1'b0;
        modelPtr      = 2'd0;
        modelDir      = dirScsiToMem;
        modelMid      = 1'b0;
        modelHalf     = 1'b0;
        partial       = '0;
        seed          = 32'h77165d4e;
        opCount       = 0;
        repeat (2) @(posedge ACR_WR);
        #1 RST_FIFO_ = 1'b1;
        @(negedge ACR_WR);
        fd = $fopen("test/fifo_input.txt", "r");
        if (fd == 0) failRun("Could not open test/fifo_input.txt");
        while ($fscanf(fd, "%s", opName) == 1) begin
            if (opName[0] == "#") begin   // Comment runs to end of line
                c = $fgetc(fd);
                while ((c != "\n") && (c != -1)) c = $fgetc(fd);
            end else begin
                case (opName)
                    "acr":     op = opAcr;
                    "memwr":   op = opMemWrite;
                    "memrd":   op = opMemRead;
                    "bytein":  op = opByteIn;
                    "byteout": op = opByteOut;
                    "flags":   op = opFlags;
                    default:   failRun($sformatf("Unknown operation %s in input file", opName));
                endcase
                nArgs = (op == opAcr) ? 2 : ((op == opFlags) ? 4 : 1);
                for (int i = 0; i < 4; i++) arg[i] = '0;
                for (int i = 0; i < nArgs; i++) begin
                    if ($fscanf(fd, "%h", arg[i]) != 1) failRun("Missing operand in input file");
                end
                runOp(op, arg[0], arg[1], arg[2], arg[3]);
                opCount++;
            end
        end
        $fclose(fd);
        stressBurst();
        if (opCount == 0) begin
            failRun("No operations were read from the input file");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- Bender.yml
package:
  name: sdmac_fifo

sources:
  # Shared header, package and RTL
  - include_dirs:
      - verilog
    files:
      - verilog/sdmacPkg.sv
      - verilog/fifoBuffer.sv
      - verilog/bytePointer.sv
      - verilog/cpuTransferFsm.sv
      - verilog/scsiTransferFsm.sv
      - verilog/sdmacFifoTop.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - test/tbSdmacFifo.sv

//--- sdmacFifoTop.f
+incdir+verilog
verilog/sdmacPkg.sv
verilog/fifoBuffer.sv
verilog/bytePointer.sv
verilog/cpuTransferFsm.sv
verilog/scsiTransferFsm.sv
verilog/sdmacFifoTop.sv
test/tbSdmacFifo.sv

//--- test/fifo_input.txt
# op then hex operands, a # token starts a comment to end of line
# acr: dir mid25 | memwr bytein: data | memrd byteout: expected | flags: empty full boEq0 boEq3
flags 1 0 1 0
memrd 0          # empty FIFO, read ignored
acr 0 0
bytein 11
bytein 22
bytein 33
bytein 44
bytein 55
bytein 66
bytein 77
bytein 88
flags 0 0 1 0
memrd 11223344
memrd 55667788
flags 1 0 1 0
acr 1 0
byteout 0        # empty FIFO, request ignored
memwr a1b2c3d4
byteout a1
byteout b2
byteout c3
flags 0 0 0 1
byteout d4
flags 1 0 1 0
acr 1 1
flags 1 0 0 0
memwr 0000dead   # upper half
memwr 0000beef   # lower half pushes
byteout be
byteout ef
flags 1 0 0 0
acr 1 0
memwr 01020304
memwr 05060708
memwr 090a0b0c
memwr 0d0e0f10
memwr 11121314
memwr 15161718
memwr 191a1b1c
memwr 1d1e1f20
flags 0 1 1 0
memwr 99999999   # ninth write ignored
flags 0 1 1 0
byteout 01
byteout 02
byteout 03
byteout 04
flags 0 0 1 0
